// ==== sim.f ====
rtl/dmaRegPkg.sv
rtl/dmaXferPkg.sv
rtl/dmaRegPort.sv
rtl/dmaChannelRegs.sv
rtl/dmaStatus.sv
rtl/dmaDatapath.sv
tb/dmaClkGen.sv
tb/dmaDatapath_asserts.sv
tb/dmaTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = dmaTb
FILELIST  = sim.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb/dmaTb.sv ====
module dmaTb
  import dmaRegPkg::*, dmaXferPkg::*;
();

  typedef enum logic [1:0] {
    rowWrite,
    rowReadCheck,
    rowXferCheck,
    rowDreqSet
  } rowKind_e;

  // value holds a data byte, an expected byte or an expected transfer
  typedef struct packed {
    rowKind_e                   kind;
    logic [regAddrWidth-1:0]    regAddr;
    logic [$bits(xferOut_t)-1:0] value;
    chanSel_t                   chan;
  } stimRow_t;

  localparam int          waitLimit = 8;
  localparam logic [15:0] lfsrSeed  = 16'd2488;

  logic                 cpuIf;
  logic                 arstN;
  cpuBus_t              cpu;
  logic [channels-1:0]  dreq;
  logic [channels-1:0]  dack;
  logic [dataWidth-1:0] rdData;
  xferOut_t             xfer;

  stimRow_t    rows [$];
  logic [15:0] lfsrState;
  int          testCount;
  int          errorCount;
  bit          aborted;

  dmaClkGen clkGen (
    .cpuIf (cpuIf),
    .arstN (arstN)
  );

  dmaDatapath DUT (
    .cpuIf  (cpuIf),
    .arstN  (arstN),
    .cpu    (cpu),
    .dreq   (dreq),
    .dack   (dack),
    .rdData (rdData),
    .xfer   (xfer)
  );

  // galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic takeBits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[14:0], lfsrState[0]};
    end
  endtask

  task automatic addRow(input rowKind_e kind, input logic [3:0] regAddr,
                        input logic [17:0] value, input chanSel_t chan);
    rows.push_back(stimRow_t'{kind: kind, regAddr: regAddr, value: value, chan: chan});
  endtask

  task automatic addWrite(input logic [3:0] regAddr, input logic [7:0] data);
    addRow(rowWrite, regAddr, {10'b0, data}, 2'd0);
  endtask

  task automatic addRead(input logic [3:0] regAddr, input logic [7:0] expected);
    addRow(rowReadCheck, regAddr, {10'b0, expected}, 2'd0);
  endtask

  // low byte first, then high byte
  task automatic addWordWrite(input logic [3:0] regAddr, input logic [15:0] word);
    addWrite(regAddr, word[7:0]);
    addWrite(regAddr, word[15:8]);
  endtask

  task automatic addWordRead(input logic [3:0] regAddr, input logic [15:0] word);
    addRead(regAddr, word[7:0]);
    addRead(regAddr, word[15:8]);
  endtask

  task automatic addXfer(input chanSel_t chan, input logic valid, input logic eop,
                         input logic [15:0] addr);
    addRow(rowXferCheck, 4'd0, {valid, eop, addr}, chan);
  endtask

  task automatic buildTable(input logic [15:0] baseA, input logic [15:0] baseB);
    // channel 1 reads zero after reset
    addWrite(addrClearFf, 8'h00);
    addWordRead(4'd2, 16'h0000);
    addWordRead(4'd3, 16'h0000);
    // channel 1, count 3, increment without autoinit
    addWrite(addrMode, 8'h01);
    addWrite(addrClearFf, 8'h00);
    addWordWrite(4'd2, baseA);
    addWordWrite(4'd3, 16'd3);
    addWrite(addrClearFf, 8'h00);
    addWordRead(4'd2, baseA);
    addWordRead(4'd3, 16'd3);
    addRow(rowDreqSet, 4'd0, 18'h00002, 2'd0);
    for (int i = 0; i <= 3; i++)
      addXfer(2'd1, 1'b1, i == 3, baseA + 16'(i));
    // past terminal count the count wraps and the address keeps going
    addXfer(2'd1, 1'b1, 1'b0, baseA + 16'd4);
    addWrite(addrClearFf, 8'h00);
    addWordRead(4'd3, 16'hFFFE);
    addRead(addrCmd, 8'h22);
    addRead(addrCmd, 8'h20);
    // channel 2, count 2, decrement with autoinit
    addWrite(addrMode, 8'h32);
    addWrite(addrClearFf, 8'h00);
    addWordWrite(4'd4, baseB);
    addWordWrite(4'd5, 16'd2);
    for (int i = 0; i <= 2; i++)
      addXfer(2'd2, 1'b1, i == 2, baseB - 16'(i));
    addXfer(2'd2, 1'b1, 1'b0, baseB);
    addXfer(2'd2, 1'b1, 1'b0, baseB - 16'd1);
    // controller disabled, dack must be ignored
    addWrite(addrCmd, 8'h04);
    addXfer(2'd2, 1'b0, 1'b0, 16'h0000);
    addXfer(2'd2, 1'b0, 1'b0, 16'h0000);
    addWrite(addrClearFf, 8'h00);
    addWordRead(4'd4, baseB - 16'd2);
  endtask

  task automatic checkByte(input logic [dataWidth-1:0] act, input logic [dataWidth-1:0] exp);
    testCount++;
    if (act !== exp)
    begin
      errorCount++;
      $display("FAIL rdData expected 0x%h got 0x%h", exp, act);
    end
    else
      $display("ok   rdData 0x%h", act);
  endtask

  task automatic checkStatus(input statusReg_t act, input statusReg_t exp);
    testCount++;
    if (act !== exp)
    begin
      errorCount++;
      $display("FAIL status expected 0x%h got 0x%h", exp, act);
    end
    else
      $display("ok   status 0x%h", act);
  endtask

  // address is only compared when a word is expected
  task automatic checkXfer(input xferOut_t act, input xferOut_t exp);
    logic match;
    testCount++;
    match = exp.valid ? (act === exp) : ({act.valid, act.eop} === 2'b00);
    if (!match)
    begin
      errorCount++;
      $display("FAIL xfer expected 0x%h got 0x%h", exp, act);
    end
    else
      $display("ok   xfer 0x%h", act);
  endtask

  task automatic applyRow(input stimRow_t row);
    xferOut_t exp;
    int       waits;
    exp = xferOut_t'(row.value);
    case (row.kind)
      rowWrite:
      begin
        cpu = '{wr: 1'b1, rd: 1'b0, regAddr: row.regAddr, wrData: row.value[7:0]};
        @(negedge cpuIf);
        cpu = '0;
      end
      rowReadCheck:
      begin
        cpu = '{wr: 1'b0, rd: 1'b1, regAddr: row.regAddr, wrData: 8'h00};
        @(negedge cpuIf);
        cpu = '0;
        if (row.regAddr == addrCmd)
          checkStatus(statusReg_t'(rdData), statusReg_t'(row.value[7:0]));
        else
          checkByte(rdData, row.value[7:0]);
      end
      rowDreqSet:
      begin
        dreq = row.value[channels-1:0];
        @(negedge cpuIf);
      end
      default:
      begin
        dack = 4'b0001 << row.chan;
        @(negedge cpuIf);
        dack = '0;
        waits = 0;
        while (exp.valid && !xfer.valid && waits < waitLimit)
        begin
          @(negedge cpuIf);
          waits++;
        end
        if (exp.valid && !xfer.valid)
        begin
          errorCount++;
          aborted = 1'b1;
          $display("timeout: no transfer came out for channel %0d", row.chan);
        end
        else
          checkXfer(xfer, exp);
      end
    endcase
  endtask

  initial
  begin
    logic [15:0] baseA;
    logic [15:0] baseB;
    int          waits;
    cpu        = '0;
    dreq       = '0;
    dack       = '0;
    lfsrState  = lfsrSeed;
    testCount  = 0;
    errorCount = 0;
    aborted    = 1'b0;
    takeBits(16, baseA);
    takeBits(16, baseB);
    buildTable(baseA, baseB);
    waits = 0;
    while (arstN !== 1'b1 && waits < waitLimit)
    begin
      @(posedge cpuIf);
      waits++;
    end
    if (arstN !== 1'b1)
    begin
      errorCount++;
      aborted = 1'b1;
      $display("timeout: reset was never released");
    end
    else
    begin
      @(negedge cpuIf);
      checkXfer(xfer, '0);
    end
    foreach (rows[i])
    begin
      if (!aborted)
        applyRow(rows[i]);
    end
    $display("%0d tests run, %0d errors", testCount, errorCount);
    if (errorCount == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== tb/dmaDatapath_asserts.sv ====
module dmaDatapath_asserts
  import dmaXferPkg::*;
(
  input logic                cpuIf,
  input logic                arstN,
  input logic [channels-1:0] dack,
  input xferOut_t            xfer,
  input logic                xferEnable,
  input logic                statusRead,
  input logic [channels-1:0] tcPulse,
  input statusReg_t          status
);

  eopWithValid: assert property (@(posedge cpuIf) disable iff (!arstN)
    xfer.eop |-> xfer.valid)
    else $error("xfer.eop high without xfer.valid");

  // every valid word comes from an enabled dack the cycle before
  validFromDack: assert property (@(posedge cpuIf) disable iff (!arstN)
    xfer.valid |-> $past(xferEnable && (dack != '0)))
    else $error("xfer.valid without an enabled dack one cycle earlier");

  tcClearedByRead: assert property (@(posedge cpuIf) disable iff (!arstN)
    (statusRead && (tcPulse == '0)) |=> (status.reachedTc == '0))
    else $error("reachedTc still set after a status read");

  dackOneHot: assert property (@(posedge cpuIf) disable iff (!arstN)
    $onehot0(dack))
    else $error("dack has more than one bit high");

endmodule

bind dmaDatapath dmaDatapath_asserts asserts (
  .cpuIf      (cpuIf),
  .arstN      (arstN),
  .dack       (dack),
  .xfer       (xfer),
  .xferEnable (xferEnable),
  .statusRead (statusRead),
  .tcPulse    (tcPulse),
  .status     (status)
);

// ==== tb/dmaClkGen.sv ====
module dmaClkGen
(
  output logic cpuIf,
  output logic arstN
);

  initial
  begin
    cpuIf = 1'b0;
    forever
      #20 cpuIf = ~cpuIf;
  end

  // three cycles of reset, released on a falling edge
  initial
  begin
    arstN = 1'b0;
    repeat (3) @(posedge cpuIf);
    @(negedge cpuIf);
    arstN = 1'b1;
  end

endmodule

// ==== rtl/dmaDatapath.sv ====
module dmaDatapath
  import dmaRegPkg::*, dmaXferPkg::*;
(
  input  logic                 cpuIf,
  input  logic                 arstN,
  input  cpuBus_t              cpu,
  input  logic [channels-1:0]  dreq,
  input  logic [channels-1:0]  dack,
  output logic [dataWidth-1:0] rdData,
  output xferOut_t             xfer
);

  regOp_e               op;
  chanSel_t             chan;
  chanMode_t            modes [channels];
  logic                 xferEnable;
  logic                 statusRead;
  logic [dataWidth-1:0] chanRdByte;
  logic [channels-1:0]  tcPulse;
  statusReg_t           status;

  dmaRegPort regPort (
    .cpuIf      (cpuIf),
    .arstN      (arstN),
    .cpu        (cpu),
    .chanRdByte (chanRdByte),
    .status     (status),
    .op         (op),
    .chan       (chan),
    .modes      (modes),
    .xferEnable (xferEnable),
    .statusRead (statusRead),
    .rdData     (rdData)
  );

  dmaChannelRegs channelRegs (
    .cpuIf      (cpuIf),
    .arstN      (arstN),
    .op         (op),
    .chan       (chan),
    .wrData     (cpu.wrData),
    .modes      (modes),
    .xferEnable (xferEnable),
    .dack       (dack),
    .chanRdByte (chanRdByte),
    .tcPulse    (tcPulse),
    .xfer       (xfer)
  );

  dmaStatus statusReg (
    .cpuIf      (cpuIf),
    .arstN      (arstN),
    .dreq       (dreq),
    .tcPulse    (tcPulse),
    .statusRead (statusRead),
    .status     (status)
  );

endmodule

// ==== rtl/dmaStatus.sv ====
module dmaStatus
  import dmaXferPkg::*;
(
  input  logic                cpuIf,
  input  logic                arstN,
  input  logic [channels-1:0] dreq,
  input  logic [channels-1:0] tcPulse,
  input  logic                statusRead,
  output statusReg_t          status
);

  // request lines sampled every cycle
  always_ff @(posedge cpuIf or negedge arstN)
  begin
    if (!arstN)
      status.request <= '0;
    else
      status.request <= dreq;
  end

  // sticky tc flags, cleared by a read
  always_ff @(posedge cpuIf or negedge arstN)
  begin
    if (!arstN)
      status.reachedTc <= '0;
    else if (statusRead)
      // a tc in the read cycle still lands
      status.reachedTc <= tcPulse;
    else
      status.reachedTc <= status.reachedTc | tcPulse;
  end

endmodule

// ==== rtl/dmaChannelRegs.sv ====
module dmaChannelRegs
  import dmaRegPkg::*, dmaXferPkg::*;
(
  input  logic                 cpuIf,
  input  logic                 arstN,
  input  regOp_e               op,
  input  chanSel_t             chan,
  input  logic [dataWidth-1:0] wrData,
  input  chanMode_t            modes [channels],
  input  logic                 xferEnable,
  input  logic [channels-1:0]  dack,
  output logic [dataWidth-1:0] chanRdByte,
  output logic [channels-1:0]  tcPulse,
  output xferOut_t             xfer
);

  logic [wordWidth-1:0] baseAddr  [channels];
  logic [wordWidth-1:0] baseCount [channels];
  logic [wordWidth-1:0] curAddr   [channels];
  logic [wordWidth-1:0] curCount  [channels];
  logic                 bytePtr;
  logic                 ackAny;
  chanSel_t             ackChan;
  logic                 xferValid;
  logic                 xferEop;
  logic [wordWidth-1:0] xferAddr;

  // acknowledged channel, dack is one-hot or zero
  always_comb
  begin
    ackChan = '0;
    for (int i = 0; i < channels; i++)
    begin
      if (dack[i])
        ackChan = chanSel_t'(i);
    end
  end

  assign ackAny = xferEnable && (dack != '0);

  // terminal count when the count is already zero before the step
  always_comb
  begin
    for (int i = 0; i < channels; i++)
      tcPulse[i] = xferEnable && dack[i] && (curCount[i] == '0);
  end

  // byte pointer, toggled on every address or count access
  always_ff @(posedge cpuIf or negedge arstN)
  begin
    if (!arstN)
      bytePtr <= 1'b0;
    else if (op == opClearFf)
      bytePtr <= 1'b0;
    else if (op inside {opWrAddr, opRdAddr, opWrCount, opRdCount})
      bytePtr <= ~bytePtr;
  end

  always_ff @(posedge cpuIf or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < channels; i++)
      begin
        baseAddr[i]  <= '0;
        baseCount[i] <= '0;
        curAddr[i]   <= '0;
        curCount[i]  <= '0;
      end
    end
    else
    begin
      // transfer step first, a cpu write to the same bytes overrides it
      if (ackAny)
      begin
        if (tcPulse[ackChan] && modes[ackChan].autoInit)
        begin
          curAddr[ackChan]  <= baseAddr[ackChan];
          curCount[ackChan] <= baseCount[ackChan];
        end
        else
        begin
          if (modes[ackChan].dir == dirDecrement)
            curAddr[ackChan] <= curAddr[ackChan] - 1'b1;
          else
            curAddr[ackChan] <= curAddr[ackChan] + 1'b1;
          curCount[ackChan] <= curCount[ackChan] - 1'b1;
        end
      end
      if (op == opWrAddr)
      begin
        if (bytePtr)
        begin
          baseAddr[chan][wordWidth-1:dataWidth] <= wrData;
          curAddr[chan][wordWidth-1:dataWidth]  <= wrData;
        end
        else
        begin
          baseAddr[chan][dataWidth-1:0] <= wrData;
          curAddr[chan][dataWidth-1:0]  <= wrData;
        end
      end
      else if (op == opWrCount)
      begin
        if (bytePtr)
        begin
          baseCount[chan][wordWidth-1:dataWidth] <= wrData;
          curCount[chan][wordWidth-1:dataWidth]  <= wrData;
        end
        else
        begin
          baseCount[chan][dataWidth-1:0] <= wrData;
          curCount[chan][dataWidth-1:0]  <= wrData;
        end
      end
    end
  end

  // read byte of current address or count
  always_comb
  begin
    case (op)
      opRdAddr:
        chanRdByte = bytePtr ? curAddr[chan][wordWidth-1:dataWidth] : curAddr[chan][dataWidth-1:0];
      opRdCount:
        chanRdByte = bytePtr ? curCount[chan][wordWidth-1:dataWidth]
                             : curCount[chan][dataWidth-1:0];
      default:
        chanRdByte = '0;
    endcase
  end

  // transfer output, pre-step address one cycle after dack
  always_ff @(posedge cpuIf or negedge arstN)
  begin
    if (!arstN)
    begin
      xferValid <= 1'b0;
      xferEop   <= 1'b0;
    end
    else
    begin
      xferValid <= ackAny;
      xferEop   <= ackAny && tcPulse[ackChan];
    end
  end

  always_ff @(posedge cpuIf)
  begin
    if (ackAny)
      xferAddr <= curAddr[ackChan];
  end

  assign xfer = '{valid: xferValid, eop: xferEop, addr: xferAddr};

endmodule

// ==== rtl/dmaRegPort.sv ====
module dmaRegPort
  import dmaRegPkg::*, dmaXferPkg::*;
(
  input  logic                 cpuIf,
  input  logic                 arstN,
  input  cpuBus_t              cpu,
  input  logic [dataWidth-1:0] chanRdByte,
  input  statusReg_t           status,
  output regOp_e               op,
  output chanSel_t             chan,
  output chanMode_t            modes [channels],
  output logic                 xferEnable,
  output logic                 statusRead,
  output logic [dataWidth-1:0] rdData
);

  logic ctrlDisable;

  // address/strobe to access opcode
  always_comb
  begin
    op = opNone;
    if (!cpu.regAddr[regAddrWidth-1])
    begin
      // bit 0 picks count over address
      if (cpu.wr)
        op = cpu.regAddr[0] ? opWrCount : opWrAddr;
      else if (cpu.rd)
        op = cpu.regAddr[0] ? opRdCount : opRdAddr;
    end
    else if (cpu.regAddr == addrCmd)
    begin
      if (cpu.wr)
        op = opWrCommand;
      else if (cpu.rd)
        op = opRdStatus;
    end
    else if (cpu.regAddr == addrMode && cpu.wr)
      op = opWrMode;
    else if (cpu.regAddr == addrClearFf && cpu.wr)
      op = opClearFf;
  end

  assign chan       = cpu.regAddr[2:1];
  assign statusRead = (op == opRdStatus);
  assign xferEnable = ~ctrlDisable;

  // only the disable bit of the command register is kept
  always_ff @(posedge cpuIf or negedge arstN)
  begin
    if (!arstN)
      ctrlDisable <= 1'b0;
    else if (op == opWrCommand)
      ctrlDisable <= cpu.wrData[cmdDisableBit];
  end

  // mode write, channel in data bits 1:0
  always_ff @(posedge cpuIf or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < channels; i++)
        modes[i] <= '0;
    end
    else if (op == opWrMode)
    begin
      modes[cpu.wrData[1:0]].autoInit <= cpu.wrData[4];
      modes[cpu.wrData[1:0]].dir      <= xferDir_e'(cpu.wrData[5]);
    end
  end

  // read data, held until the next read
  always_ff @(posedge cpuIf or negedge arstN)
  begin
    if (!arstN)
      rdData <= '0;
    else if (cpu.rd)
    begin
      case (op)
        opRdAddr, opRdCount: rdData <= chanRdByte;
        opRdStatus:          rdData <= status;
        default:             rdData <= '0;
      endcase
    end
  end

endmodule

// ==== rtl/dmaXferPkg.sv ====
package dmaXferPkg;

  localparam int channels  = 4;
  localparam int wordWidth = 16;

  typedef logic [1:0] chanSel_t;

  // address step direction, mode bit 5
  typedef enum logic {
    dirIncrement,
    dirDecrement
  } xferDir_e;

  typedef struct packed {
    logic     autoInit;
    xferDir_e dir;
  } chanMode_t;

  // request lines high, sticky tc flags low
  typedef struct packed {
    logic [channels-1:0] request;
    logic [channels-1:0] reachedTc;
  } statusReg_t;

  typedef struct packed {
    logic                 valid;
    logic                 eop;
    logic [wordWidth-1:0] addr;
  } xferOut_t;

endpackage

// ==== rtl/dmaRegPkg.sv ====
package dmaRegPkg;

  // cpu side widths
  localparam int dataWidth    = 8;
  localparam int regAddrWidth = 4;

  // fixed register addresses, channel registers sit at 0..7
  localparam logic [regAddrWidth-1:0] addrCmd     = 4'd8;
  localparam logic [regAddrWidth-1:0] addrMode    = 4'd11;
  localparam logic [regAddrWidth-1:0] addrClearFf = 4'd12;

  // controller disable bit of the command register
  localparam int cmdDisableBit = 2;

  // decoded register access
  typedef enum logic [3:0] {
    opNone,
    opWrAddr,
    opRdAddr,
    opWrCount,
    opRdCount,
    opWrCommand,
    opRdStatus,
    opWrMode,
    opClearFf
  } regOp_e;

  // one cpu access per cycle, wr and rd never together
  typedef struct packed {
    logic                    wr;
    logic                    rd;
    logic [regAddrWidth-1:0] regAddr;
    logic [dataWidth-1:0]    wrData;
  } cpuBus_t;

endpackage
